//--- source/dma_path_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared types for the FPU DMA request path
// beat, length, address, form and command widths
// header field positions and message form codes
// state encodings for the arbiter, intake and dispatch FSMs
//////////////////////////////////////////////////////////////////////
`default_nettype none

package dma_path_pkg;

	localparam int NUM_PORTS = 4;

	typedef logic [127:0] beat_t;       // one bus beat
	typedef logic [15:0]  length_t;     // beats, header included
	typedef logic [39:0]  dram_addr_t;
	typedef logic [15:0]  dpram_addr_t;
	typedef logic [7:0]   msg_form_t;
	typedef logic [1:0]   port_id_t;    // 0 is port a
	typedef logic [71:0]  cmd_t;        // {length, dram addr, dpram addr}

	// header layout
	localparam int FORM_LSB  = 72;      // form in 79:72
	localparam int LEN_LSB   = 56;      // length in 71:56
	localparam int DRAM_LSB  = 16;      // dram addr in 55:16, dpram below
	localparam int OWNER_LSB = 14;      // owner field of the dpram addr

	localparam msg_form_t MSG_READ  = 8'h01;
	localparam msg_form_t MSG_WRITE = 8'h03;

	typedef enum logic [2:0] {
		ARB_LOOK_A, ARB_LOOK_B, ARB_LOOK_C, ARB_LOOK_D, ARB_BUSY
	} arb_state_t;

	typedef enum logic [1:0] {
		INTAKE_IDLE, INTAKE_HEADER, INTAKE_BODY, INTAKE_DONE
	} intake_state_t;

	typedef enum logic [2:0] {
		DISP_IDLE, DISP_DECODE, DISP_READ_CMD,
		DISP_WRITE_CMD, DISP_WRITE_BODY, DISP_FINISH
	} dispatch_state_t;

endpackage

`default_nettype wire

//--- source/sync_fifo.sv
//////////////////////////////////////////////////////////////////////
// single clock first-word-fall-through FIFO
// head entry always shown on pop_data
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH      = 8,
	parameter int DEPTH_LOG2 = 4
) (
	input  wire              fpu_clk,
	input  wire              reset,
	input  wire              push,
	input  wire [WIDTH-1:0]  push_data,
	output logic             full,
	input  wire              pop,
	output logic [WIDTH-1:0] pop_data,
	output logic             empty
);

	logic [WIDTH-1:0] mem [0:(1 << DEPTH_LOG2) - 1];
	logic [DEPTH_LOG2-1:0] wr_ptr;
	logic [DEPTH_LOG2-1:0] rd_ptr;
	logic [DEPTH_LOG2:0] count;     // one extra bit so full is the msb
	logic do_push;
	logic do_pop;

	assign do_push  = push && !full;    // push while full is dropped
	assign do_pop   = pop && !empty;
	assign full     = count[DEPTH_LOG2];
	assign empty    = (count == '0);
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge fpu_clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

endmodule

`default_nettype wire

//--- source/port_arbiter.sv
//////////////////////////////////////////////////////////////////////
// round-robin grant over the four FPU DMA ports
// burst intake into the burst FIFO, owner queued per burst
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module port_arbiter (
	input  wire                     fpu_clk,
	input  wire                     reset,
	input  wire                     dma_req_a,
	input  wire                     dma_req_b,
	input  wire                     dma_req_c,
	input  wire                     dma_req_d,
	output logic                    dma_resp_a,
	output logic                    dma_resp_b,
	output logic                    dma_resp_c,
	output logic                    dma_resp_d,
	input  wire                     dma_write_valid_a,
	input  wire                     dma_write_valid_b,
	input  wire                     dma_write_valid_c,
	input  wire                     dma_write_valid_d,
	input  wire dma_path_pkg::beat_t dma_write_data_a,
	input  wire dma_path_pkg::beat_t dma_write_data_b,
	input  wire dma_path_pkg::beat_t dma_write_data_c,
	input  wire dma_path_pkg::beat_t dma_write_data_d,
	output logic                    dma_write_ready_a,
	output logic                    dma_write_ready_b,
	output logic                    dma_write_ready_c,
	output logic                    dma_write_ready_d,
	input  wire                     burst_full,
	output logic                    burst_push,
	output dma_path_pkg::beat_t     burst_data,
	output logic                    owner_push,
	output dma_path_pkg::port_id_t  owner_id
);

	dma_path_pkg::arb_state_t    arb_state;
	dma_path_pkg::intake_state_t intake_state;
	dma_path_pkg::port_id_t      grant_id;
	dma_path_pkg::port_id_t      pick_id;
	dma_path_pkg::msg_form_t     hdr_form;
	dma_path_pkg::length_t       hdr_len;
	dma_path_pkg::length_t       burst_len;
	dma_path_pkg::length_t       beat_cnt;
	dma_path_pkg::beat_t         wr_data [dma_path_pkg::NUM_PORTS];
	logic [dma_path_pkg::NUM_PORTS-1:0] req;
	logic [dma_path_pkg::NUM_PORTS-1:0] valid;
	logic [dma_path_pkg::NUM_PORTS-1:0] sel;
	logic pick_valid;
	logic granted;
	logic hdr_wait;
	logic rdy;
	logic beat_fire;

	assign req   = {dma_req_d, dma_req_c, dma_req_b, dma_req_a};
	assign valid = {dma_write_valid_d, dma_write_valid_c, dma_write_valid_b, dma_write_valid_a};
	assign wr_data[0] = dma_write_data_a;
	assign wr_data[1] = dma_write_data_b;
	assign wr_data[2] = dma_write_data_c;
	assign wr_data[3] = dma_write_data_d;

	//////////////////////////////////////////////////////////////////////
	// grant
	//////////////////////////////////////////////////////////////////////

	// search starts at the port the look state names, lowest offset wins
	always_comb begin
		dma_path_pkg::port_id_t idx;
		pick_valid = 1'b0;
		pick_id    = '0;
		for (int k = dma_path_pkg::NUM_PORTS - 1; k >= 0; k--) begin
			idx = dma_path_pkg::port_id_t'(arb_state) + dma_path_pkg::port_id_t'(k);
			if (req[idx]) begin
				pick_valid = 1'b1;
				pick_id    = idx;
			end
		end
	end

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			arb_state <= dma_path_pkg::ARB_LOOK_A;
			grant_id  <= '0;
		end else begin
			case (arb_state)
				dma_path_pkg::ARB_BUSY: begin
					// next round starts after the port just served
					if (intake_state == dma_path_pkg::INTAKE_DONE)
						arb_state <= dma_path_pkg::arb_state_t'({1'b0, grant_id + 2'd1});
				end
				default: begin
					if (pick_valid) begin
						grant_id  <= pick_id;
						arb_state <= dma_path_pkg::ARB_BUSY;
					end
				end
			endcase
		end
	end

	assign granted = (arb_state == dma_path_pkg::ARB_BUSY);

	always_comb begin
		for (int i = 0; i < dma_path_pkg::NUM_PORTS; i++) begin
			sel[i] = granted && (grant_id == dma_path_pkg::port_id_t'(i));
		end
	end

	//////////////////////////////////////////////////////////////////////
	// intake
	//////////////////////////////////////////////////////////////////////

	assign hdr_wait   = (intake_state == dma_path_pkg::INTAKE_HEADER);
	assign rdy        = (hdr_wait || intake_state == dma_path_pkg::INTAKE_BODY) && !burst_full;
	assign burst_data = wr_data[grant_id];
	assign beat_fire  = rdy && valid[grant_id];
	assign burst_push = beat_fire;
	assign hdr_form   = burst_data[dma_path_pkg::FORM_LSB +: 8];
	assign hdr_len    = burst_data[dma_path_pkg::LEN_LSB +: 16];

	// owner queued with its header so the dispatcher can pop both at once
	assign owner_push = beat_fire && hdr_wait;
	assign owner_id   = grant_id;

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			intake_state <= dma_path_pkg::INTAKE_IDLE;
			burst_len    <= '0;
			beat_cnt     <= '0;
		end else begin
			case (intake_state)
				dma_path_pkg::INTAKE_IDLE: begin
					if (!granted && pick_valid)     // same edge as the grant
						intake_state <= dma_path_pkg::INTAKE_HEADER;
				end
				dma_path_pkg::INTAKE_HEADER: begin
					if (beat_fire) begin
						burst_len <= hdr_len;
						beat_cnt  <= 16'd1;
						if (hdr_form == dma_path_pkg::MSG_WRITE && hdr_len > 16'd1)
							intake_state <= dma_path_pkg::INTAKE_BODY;
						else
							intake_state <= dma_path_pkg::INTAKE_DONE;  // read or unknown
					end
				end
				dma_path_pkg::INTAKE_BODY: begin
					if (beat_fire) begin
						beat_cnt <= beat_cnt + 16'd1;
						if (beat_cnt + 16'd1 == burst_len)
							intake_state <= dma_path_pkg::INTAKE_DONE;
					end
				end
				default: intake_state <= dma_path_pkg::INTAKE_IDLE;
			endcase
		end
	end

	assign dma_resp_a = sel[0] && hdr_wait;
	assign dma_resp_b = sel[1] && hdr_wait;
	assign dma_resp_c = sel[2] && hdr_wait;
	assign dma_resp_d = sel[3] && hdr_wait;
	assign dma_write_ready_a = sel[0] && rdy;
	assign dma_write_ready_b = sel[1] && rdy;
	assign dma_write_ready_c = sel[2] && rdy;
	assign dma_write_ready_d = sel[3] && rdy;

endmodule

`default_nettype wire

//--- source/cmd_dispatch.sv
//////////////////////////////////////////////////////////////////////
// control FSM between burst FIFO and the command queues
// decodes headers, stamps the owner into the dpram address
// forwards write data beats to the write data FIFO
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cmd_dispatch (
	input  wire                         fpu_clk,
	input  wire                         reset,
	input  wire dma_path_pkg::beat_t    burst_data,
	input  wire                         burst_empty,
	output logic                        burst_pop,
	input  wire dma_path_pkg::port_id_t owner_id,
	output logic                        owner_pop,
	output logic                        rcmd_push,
	output logic                        wcmd_push,
	output dma_path_pkg::cmd_t          cmd_data,
	input  wire                         wdata_full,
	output logic                        wdata_push
);

	dma_path_pkg::dispatch_state_t state;
	dma_path_pkg::msg_form_t   hdr_form;
	dma_path_pkg::length_t     hdr_len;
	dma_path_pkg::dram_addr_t  hdr_dram;
	dma_path_pkg::dpram_addr_t hdr_dpram;
	dma_path_pkg::dpram_addr_t stamped_dpram;
	dma_path_pkg::port_id_t    owner;
	dma_path_pkg::length_t     body_cnt;
	logic take_hdr;
	logic fwd_beat;

	assign take_hdr = (state == dma_path_pkg::DISP_IDLE) && !burst_empty;
	assign fwd_beat = (state == dma_path_pkg::DISP_WRITE_BODY) && (body_cnt < hdr_len)
		&& !burst_empty && !wdata_full;

	assign burst_pop  = take_hdr || fwd_beat;
	assign owner_pop  = take_hdr;
	assign wdata_push = fwd_beat;
	assign rcmd_push  = (state == dma_path_pkg::DISP_READ_CMD);
	assign wcmd_push  = (state == dma_path_pkg::DISP_WRITE_CMD);

	// owner in 15:14, 13:12 cleared
	always_comb begin
		stamped_dpram = hdr_dpram;
		stamped_dpram[dma_path_pkg::OWNER_LSB +: 2] = owner;
		stamped_dpram[dma_path_pkg::OWNER_LSB - 1 -: 2] = 2'b00;
	end

	assign cmd_data = {hdr_len, hdr_dram, stamped_dpram};

	always_ff @(posedge fpu_clk) begin
		if (take_hdr) begin
			hdr_form  <= burst_data[dma_path_pkg::FORM_LSB +: 8];
			hdr_len   <= burst_data[dma_path_pkg::LEN_LSB +: 16];
			hdr_dram  <= burst_data[dma_path_pkg::DRAM_LSB +: 40];
			hdr_dpram <= burst_data[dma_path_pkg::DRAM_LSB - 1:0];
			owner     <= owner_id;
		end
	end

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			state    <= dma_path_pkg::DISP_IDLE;
			body_cnt <= '0;
		end else begin
			case (state)
				dma_path_pkg::DISP_IDLE: begin
					if (take_hdr)
						state <= dma_path_pkg::DISP_DECODE;
				end
				dma_path_pkg::DISP_DECODE: begin
					if (hdr_form == dma_path_pkg::MSG_READ)
						state <= dma_path_pkg::DISP_READ_CMD;
					else if (hdr_form == dma_path_pkg::MSG_WRITE)
						state <= dma_path_pkg::DISP_WRITE_CMD;
					else
						state <= dma_path_pkg::DISP_IDLE;   // header already dropped
				end
				dma_path_pkg::DISP_WRITE_CMD: begin
					body_cnt <= 16'd1;                      // header counts as one
					state    <= dma_path_pkg::DISP_WRITE_BODY;
				end
				dma_path_pkg::DISP_WRITE_BODY: begin
					if (body_cnt >= hdr_len)
						state <= dma_path_pkg::DISP_FINISH;
					else if (fwd_beat)
						body_cnt <= body_cnt + 16'd1;
				end
				default: state <= dma_path_pkg::DISP_IDLE;  // read cmd, finish
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/write_issuer.sv
//////////////////////////////////////////////////////////////////////
// write command issue to the DMA engine
// one latched command, data beats streamed under wcc_ready
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module write_issuer (
	input  wire                         fpu_clk,
	input  wire                         reset,
	input  wire dma_path_pkg::cmd_t     wcmd_data,
	input  wire                         wcmd_empty,
	output logic                        wcmd_pop,
	input  wire dma_path_pkg::beat_t    wdata,
	input  wire                         wdata_empty,
	output logic                        wdata_pop,
	input  wire                         wcc_ready,
	output logic                        wcc_valid,
	output dma_path_pkg::length_t       wcc_length,
	output dma_path_pkg::dram_addr_t    wcc_dram_addr,
	output dma_path_pkg::dpram_addr_t   wcc_dpram_addr,
	output dma_path_pkg::beat_t         wcc_write_data
);

	dma_path_pkg::length_t beat_cnt;    // starts at 1 for the header
	logic busy;
	logic start;
	logic fire;

	assign start          = !busy && !wcmd_empty && !wdata_empty;
	assign wcmd_pop       = start;
	assign wcc_valid      = busy && (beat_cnt < wcc_length) && !wdata_empty;
	assign fire           = wcc_valid && wcc_ready;
	assign wdata_pop      = fire;
	assign wcc_write_data = wdata;      // head of the data FIFO

	always_ff @(posedge fpu_clk) begin
		if (start)
			{wcc_length, wcc_dram_addr, wcc_dpram_addr} <= wcmd_data;
	end

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			busy     <= 1'b0;
			beat_cnt <= '0;
		end else if (start) begin
			busy     <= 1'b1;
			beat_cnt <= 16'd1;
		end else if (busy) begin
			if (beat_cnt >= wcc_length)
				busy <= 1'b0;               // all data beats out
			else if (fire)
				beat_cnt <= beat_cnt + 16'd1;
		end
	end

endmodule

`default_nettype wire

//--- source/dma_path_top.sv
//////////////////////////////////////////////////////////////////////
// top of the FPU DMA request path
// arbiter, burst/owner/command/data FIFOs, dispatcher, write issuer
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dma_path_top #(
	parameter int BURST_DEPTH_LOG2 = 8,
	parameter int CMD_DEPTH_LOG2   = 5,
	parameter int OWNER_DEPTH_LOG2 = 8
) (
	input  wire                            fpu_clk,
	input  wire                            reset,
	input  wire                            dma_req_a,
	input  wire                            dma_req_b,
	input  wire                            dma_req_c,
	input  wire                            dma_req_d,
	output wire                            dma_resp_a,
	output wire                            dma_resp_b,
	output wire                            dma_resp_c,
	output wire                            dma_resp_d,
	input  wire                            dma_write_valid_a,
	input  wire                            dma_write_valid_b,
	input  wire                            dma_write_valid_c,
	input  wire                            dma_write_valid_d,
	input  wire dma_path_pkg::beat_t       dma_write_data_a,
	input  wire dma_path_pkg::beat_t       dma_write_data_b,
	input  wire dma_path_pkg::beat_t       dma_write_data_c,
	input  wire dma_path_pkg::beat_t       dma_write_data_d,
	output wire                            dma_write_ready_a,
	output wire                            dma_write_ready_b,
	output wire                            dma_write_ready_c,
	output wire                            dma_write_ready_d,
	input  wire                            rcc_ready,
	output wire                            rcc_valid,
	output wire dma_path_pkg::length_t     rcc_length,
	output wire dma_path_pkg::dram_addr_t  rcc_dram_addr,
	output wire dma_path_pkg::dpram_addr_t rcc_dpram_addr,
	input  wire                            wcc_ready,
	output wire                            wcc_valid,
	output wire dma_path_pkg::length_t     wcc_length,
	output wire dma_path_pkg::dram_addr_t  wcc_dram_addr,
	output wire dma_path_pkg::dpram_addr_t wcc_dpram_addr,
	output wire dma_path_pkg::beat_t       wcc_write_data
);

	dma_path_pkg::beat_t    burst_in;
	dma_path_pkg::beat_t    burst_head;
	dma_path_pkg::beat_t    wdata_head;
	dma_path_pkg::port_id_t owner_in;
	dma_path_pkg::port_id_t owner_head;
	dma_path_pkg::cmd_t     cmd_data;
	dma_path_pkg::cmd_t     rcmd_head;
	dma_path_pkg::cmd_t     wcmd_head;
	logic burst_push;
	logic burst_full;
	logic burst_pop;
	logic burst_empty;
	logic owner_push;
	logic owner_full;
	logic owner_pop;
	logic intake_full;
	logic rcmd_push;
	logic rcmd_empty;
	logic wcmd_push;
	logic wcmd_pop;
	logic wcmd_empty;
	logic wdata_push;
	logic wdata_full;
	logic wdata_pop;
	logic wdata_empty;

	assign intake_full = burst_full || owner_full;   // hold intake if either queue is full

	port_arbiter u_arbiter (
		.fpu_clk           (fpu_clk),
		.reset             (reset),
		.dma_req_a         (dma_req_a),
		.dma_req_b         (dma_req_b),
		.dma_req_c         (dma_req_c),
		.dma_req_d         (dma_req_d),
		.dma_resp_a        (dma_resp_a),
		.dma_resp_b        (dma_resp_b),
		.dma_resp_c        (dma_resp_c),
		.dma_resp_d        (dma_resp_d),
		.dma_write_valid_a (dma_write_valid_a),
		.dma_write_valid_b (dma_write_valid_b),
		.dma_write_valid_c (dma_write_valid_c),
		.dma_write_valid_d (dma_write_valid_d),
		.dma_write_data_a  (dma_write_data_a),
		.dma_write_data_b  (dma_write_data_b),
		.dma_write_data_c  (dma_write_data_c),
		.dma_write_data_d  (dma_write_data_d),
		.dma_write_ready_a (dma_write_ready_a),
		.dma_write_ready_b (dma_write_ready_b),
		.dma_write_ready_c (dma_write_ready_c),
		.dma_write_ready_d (dma_write_ready_d),
		.burst_full        (intake_full),
		.burst_push        (burst_push),
		.burst_data        (burst_in),
		.owner_push        (owner_push),
		.owner_id          (owner_in)
	);

	//////////////////////////////////////////////////////////////////////
	// queues
	//////////////////////////////////////////////////////////////////////

	sync_fifo #(.WIDTH($bits(dma_path_pkg::beat_t)), .DEPTH_LOG2(BURST_DEPTH_LOG2)) u_burst_fifo (
		.fpu_clk (fpu_clk), .reset (reset),
		.push (burst_push), .push_data (burst_in), .full (burst_full),
		.pop (burst_pop), .pop_data (burst_head), .empty (burst_empty)
	);

	sync_fifo #(.WIDTH($bits(dma_path_pkg::port_id_t)), .DEPTH_LOG2(OWNER_DEPTH_LOG2)) u_owner_fifo (
		.fpu_clk (fpu_clk), .reset (reset),
		.push (owner_push), .push_data (owner_in), .full (owner_full),
		.pop (owner_pop), .pop_data (owner_head), .empty ()
	);

	// read commands leave straight from the queue head
	sync_fifo #(.WIDTH($bits(dma_path_pkg::cmd_t)), .DEPTH_LOG2(CMD_DEPTH_LOG2)) u_rcmd_fifo (
		.fpu_clk (fpu_clk), .reset (reset),
		.push (rcmd_push), .push_data (cmd_data), .full (),
		.pop (rcc_valid && rcc_ready), .pop_data (rcmd_head), .empty (rcmd_empty)
	);

	sync_fifo #(.WIDTH($bits(dma_path_pkg::cmd_t)), .DEPTH_LOG2(CMD_DEPTH_LOG2)) u_wcmd_fifo (
		.fpu_clk (fpu_clk), .reset (reset),
		.push (wcmd_push), .push_data (cmd_data), .full (),
		.pop (wcmd_pop), .pop_data (wcmd_head), .empty (wcmd_empty)
	);

	sync_fifo #(.WIDTH($bits(dma_path_pkg::beat_t)), .DEPTH_LOG2(BURST_DEPTH_LOG2)) u_wdata_fifo (
		.fpu_clk (fpu_clk), .reset (reset),
		.push (wdata_push), .push_data (burst_head), .full (wdata_full),
		.pop (wdata_pop), .pop_data (wdata_head), .empty (wdata_empty)
	);

	assign rcc_valid = !rcmd_empty;
	assign {rcc_length, rcc_dram_addr, rcc_dpram_addr} = rcmd_head;

	cmd_dispatch u_dispatch (
		.fpu_clk     (fpu_clk),
		.reset       (reset),
		.burst_data  (burst_head),
		.burst_empty (burst_empty),
		.burst_pop   (burst_pop),
		.owner_id    (owner_head),
		.owner_pop   (owner_pop),
		.rcmd_push   (rcmd_push),
		.wcmd_push   (wcmd_push),
		.cmd_data    (cmd_data),
		.wdata_full  (wdata_full),
		.wdata_push  (wdata_push)
	);

	write_issuer u_issuer (
		.fpu_clk        (fpu_clk),
		.reset          (reset),
		.wcmd_data      (wcmd_head),
		.wcmd_empty     (wcmd_empty),
		.wcmd_pop       (wcmd_pop),
		.wdata          (wdata_head),
		.wdata_empty    (wdata_empty),
		.wdata_pop      (wdata_pop),
		.wcc_ready      (wcc_ready),
		.wcc_valid      (wcc_valid),
		.wcc_length     (wcc_length),
		.wcc_dram_addr  (wcc_dram_addr),
		.wcc_dpram_addr (wcc_dpram_addr),
		.wcc_write_data (wcc_write_data)
	);

endmodule

`default_nettype wire

//--- tests/dma_path_props.sv
//////////////////////////////////////////////////////////////////////
// concurrent checks bound into the DMA path top level
// grant exclusivity, write command hold, idle outputs in reset
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dma_path_props (
	input wire                            fpu_clk,
	input wire                            reset,
	input wire                            dma_resp_a,
	input wire                            dma_resp_b,
	input wire                            dma_resp_c,
	input wire                            dma_resp_d,
	input wire                            dma_write_ready_a,
	input wire                            dma_write_ready_b,
	input wire                            dma_write_ready_c,
	input wire                            dma_write_ready_d,
	input wire                            rcc_valid,
	input wire                            wcc_valid,
	input wire                            wcc_ready,
	input wire dma_path_pkg::length_t     wcc_length,
	input wire dma_path_pkg::dram_addr_t  wcc_dram_addr,
	input wire dma_path_pkg::dpram_addr_t wcc_dpram_addr,
	input wire dma_path_pkg::beat_t       wcc_write_data
);

	one_resp: assert property (@(posedge fpu_clk) disable iff (reset)
		$onehot0({dma_resp_a, dma_resp_b, dma_resp_c, dma_resp_d}))
		else $error("more than one dma_resp high");

	one_ready: assert property (@(posedge fpu_clk) disable iff (reset)
		$onehot0({dma_write_ready_a, dma_write_ready_b, dma_write_ready_c, dma_write_ready_d}))
		else $error("more than one dma_write_ready high");

	// stalled write beat keeps command and data
	wcc_hold: assert property (@(posedge fpu_clk) disable iff (reset)
		wcc_valid && !wcc_ready |=> wcc_valid
			&& $stable({wcc_length, wcc_dram_addr, wcc_dpram_addr, wcc_write_data}))
		else $error("wcc outputs changed while stalled");

	quiet_in_reset: assert property (@(posedge fpu_clk) reset |-> !rcc_valid && !wcc_valid)
		else $error("command valid during reset");

endmodule

bind dma_path_top dma_path_props u_props (.*);

`default_nettype wire

//--- tests/tb_dma_path.sv
//////////////////////////////////////////////////////////////////////
// testbench for the FPU DMA request path
// port burst drivers, random output stalls, reference model
// scoreboard compare of read commands and write beats, watchdog
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_dma_path;

	localparam int TOTAL_BEATS     = 86;    // sum of every burst length sent below
	localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 8 + 1000;

	logic fpu_clk;
	logic reset;
	logic req [4];
	logic valid [4];
	dma_path_pkg::beat_t wdata [4];
	wire [3:0] resp;
	wire [3:0] ready;
	logic rcc_ready;
	logic wcc_ready;
	wire rcc_valid;
	wire wcc_valid;
	wire dma_path_pkg::length_t     rcc_length;
	wire dma_path_pkg::dram_addr_t  rcc_dram_addr;
	wire dma_path_pkg::dpram_addr_t rcc_dpram_addr;
	wire dma_path_pkg::length_t     wcc_length;
	wire dma_path_pkg::dram_addr_t  wcc_dram_addr;
	wire dma_path_pkg::dpram_addr_t wcc_dpram_addr;
	wire dma_path_pkg::beat_t       wcc_write_data;
	integer seed = 69144;
	logic stall_en;
	dma_path_pkg::beat_t port_q [4][$];     // beats of the next burst per port
	dma_path_pkg::cmd_t  exp_rcmd [$];
	dma_path_pkg::cmd_t  exp_wcmd [$];      // one entry per write beat
	dma_path_pkg::beat_t exp_wbeat [$];

	dma_path_top u_dut (
		.fpu_clk (fpu_clk), .reset (reset),
		.dma_req_a (req[0]), .dma_req_b (req[1]), .dma_req_c (req[2]), .dma_req_d (req[3]),
		.dma_resp_a (resp[0]), .dma_resp_b (resp[1]),
		.dma_resp_c (resp[2]), .dma_resp_d (resp[3]),
		.dma_write_valid_a (valid[0]), .dma_write_valid_b (valid[1]),
		.dma_write_valid_c (valid[2]), .dma_write_valid_d (valid[3]),
		.dma_write_data_a (wdata[0]), .dma_write_data_b (wdata[1]),
		.dma_write_data_c (wdata[2]), .dma_write_data_d (wdata[3]),
		.dma_write_ready_a (ready[0]), .dma_write_ready_b (ready[1]),
		.dma_write_ready_c (ready[2]), .dma_write_ready_d (ready[3]),
		.rcc_ready (rcc_ready), .rcc_valid (rcc_valid), .rcc_length (rcc_length),
		.rcc_dram_addr (rcc_dram_addr), .rcc_dpram_addr (rcc_dpram_addr),
		.wcc_ready (wcc_ready), .wcc_valid (wcc_valid), .wcc_length (wcc_length),
		.wcc_dram_addr (wcc_dram_addr), .wcc_dpram_addr (wcc_dpram_addr),
		.wcc_write_data (wcc_write_data)
	);

	initial begin
		fpu_clk = 1'b0;
		forever #20 fpu_clk = ~fpu_clk;
	end

	//////////////////////////////////////////////////////////////////////
	// reference model and compare tasks
	//////////////////////////////////////////////////////////////////////

	function automatic dma_path_pkg::beat_t make_header(input dma_path_pkg::msg_form_t form,
			input dma_path_pkg::length_t len, input dma_path_pkg::dram_addr_t dram,
			input dma_path_pkg::dpram_addr_t dpram);
		return {48'h0, form, len, dram, dpram};
	endfunction

	// length and dram address pass through
	// owner lands in 15:14 and 13:12 is cleared
	function automatic dma_path_pkg::cmd_t expect_cmd(input dma_path_pkg::beat_t hdr,
			input dma_path_pkg::port_id_t port);
		dma_path_pkg::dpram_addr_t dpram;
		dpram = {port, 2'b00, hdr[11:0]};
		return {hdr[71:56], hdr[55:16], dpram};
	endfunction

	function automatic dma_path_pkg::beat_t random_beat();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	task automatic check_cmd(input string name, input dma_path_pkg::cmd_t got,
			input dma_path_pkg::cmd_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
			$display("Something failed");
			$fatal(1, "command mismatch");
		end
	endtask

	task automatic check_beat(input string name, input dma_path_pkg::beat_t got,
			input dma_path_pkg::beat_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
			$display("Something failed");
			$fatal(1, "data mismatch");
		end
	endtask

	task automatic check_quiet(input string when_txt);
		logic [9:0] flags;
		flags = {resp, ready, rcc_valid, wcc_valid};
		if (flags !== 10'b0) begin
			$display("[ERROR] %0t resp/ready/rcc_valid/wcc_valid %s got %b expected %b",
				$time, when_txt, flags, 10'b0);
			$display("Something failed");
			$fatal(1, "outputs not idle");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic queue_read(input int p, input dma_path_pkg::dram_addr_t dram,
			input dma_path_pkg::dpram_addr_t dpram);
		dma_path_pkg::beat_t hdr;
		hdr = make_header(8'h01, 16'd1, dram, dpram);
		port_q[p].push_back(hdr);
		exp_rcmd.push_back(expect_cmd(hdr, 2'(p)));
	endtask

	task automatic queue_write(input int p, input int len, input dma_path_pkg::dram_addr_t dram,
			input dma_path_pkg::dpram_addr_t dpram);
		dma_path_pkg::beat_t hdr;
		dma_path_pkg::beat_t beat;
		hdr = make_header(8'h03, 16'(len), dram, dpram);
		port_q[p].push_back(hdr);
		for (int i = 1; i < len; i++) begin    // len - 1 data beats
			beat = random_beat();
			port_q[p].push_back(beat);
			exp_wcmd.push_back(expect_cmd(hdr, 2'(p)));
			exp_wbeat.push_back(beat);
		end
	endtask

	// sends the queued burst of port p and holds req until its last beat
	task automatic send_burst(input int p);
		logic first;
		if (port_q[p].size() != 0) begin
			first = 1'b1;
			req[p]   <= 1'b1;
			valid[p] <= 1'b1;
			wdata[p] <= port_q[p][0];
			while (port_q[p].size() != 0) begin
				@(posedge fpu_clk);
				if (ready[p] && valid[p]) begin
					if (first && !resp[p]) begin
						$display("port %0d header taken without dma_resp at %0t", p, $time);
						$display("Something failed");
						$fatal(1, "handshake error");
					end
					if (!first && resp[p]) begin
						$display("port %0d dma_resp still high on a data beat at %0t",
							p, $time);
						$display("Something failed");
						$fatal(1, "handshake error");
					end
					first = 1'b0;
					void'(port_q[p].pop_front());
					if (port_q[p].size() != 0)
						wdata[p] <= port_q[p][0];
				end
			end
			req[p]   <= 1'b0;
			valid[p] <= 1'b0;
		end
	endtask

	task automatic run_ports();
		fork
			send_burst(0);
			send_burst(1);
			send_burst(2);
			send_burst(3);
		join
	endtask

	// random output back-pressure on about one cycle in four
	always @(posedge fpu_clk) begin
		if (stall_en) begin
			rcc_ready <= ($random(seed) & 3) != 0;
			wcc_ready <= ($random(seed) & 3) != 0;
		end else begin
			rcc_ready <= 1'b1;
			wcc_ready <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// scoreboard
	//////////////////////////////////////////////////////////////////////

	always @(posedge fpu_clk) begin
		if (!reset && rcc_valid && rcc_ready) begin
			if (exp_rcmd.size() == 0) begin
				$display("read command seen with none expected at %0t", $time);
				$display("Something failed");
				$fatal(1, "unexpected read command");
			end else begin
				check_cmd("rcc_cmd", {rcc_length, rcc_dram_addr, rcc_dpram_addr},
					exp_rcmd.pop_front());
			end
		end
		if (!reset && wcc_valid && wcc_ready) begin
			if (exp_wbeat.size() == 0) begin
				$display("write beat seen with none expected at %0t", $time);
				$display("Something failed");
				$fatal(1, "unexpected write beat");
			end else begin
				check_cmd("wcc_cmd", {wcc_length, wcc_dram_addr, wcc_dpram_addr},
					exp_wcmd.pop_front());
				check_beat("wcc_write_data", wcc_write_data, exp_wbeat.pop_front());
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge fpu_clk);
		$display("timeout after %0d cycles with results still pending", WATCHDOG_CYCLES);
		$display("Something failed");
		$fatal(1, "watchdog");
	end

	initial begin
		reset     = 1'b0;
		rcc_ready = 1'b0;
		wcc_ready = 1'b0;
		stall_en  = 1'b0;
		for (int i = 0; i < 4; i++) begin
			req[i]   = 1'b0;
			valid[i] = 1'b0;
			wdata[i] = '0;
		end
		@(posedge fpu_clk);
		reset <= 1'b1;
		repeat (10) begin
			@(posedge fpu_clk);
			check_quiet("during reset");
		end
		reset <= 1'b0;
		@(posedge fpu_clk);
		check_quiet("after reset");

		queue_read(2, 40'h00_1234_5670, 16'hF5A5);     // port c with 15:12 all set
		run_ports();
		queue_write(1, 6, 40'h00_2000_0040, 16'h7123);  // port b write
		run_ports();

		// d served last so the full round starts at a
		queue_read(3, 40'h00_2800_0000, 16'h0010);
		run_ports();
		for (int p = 0; p < 4; p++)
			queue_read(p, 40'h30_0000_0000 | 40'(p), 16'hFFFF);
		run_ports();
		for (int p = 0; p < 4; p++)
			queue_write(p, p + 2, {8'h40, $random(seed)}, 16'h2000 | 16'(p));
		run_ports();

		stall_en <= 1'b1;
		repeat (3) begin
			queue_write(0, 7, {8'h50, $random(seed)}, 16'($random(seed)));
			queue_read(1, {8'h60, $random(seed)}, 16'($random(seed)));
			queue_write(2, 9, {8'h70, $random(seed)}, 16'($random(seed)));
			queue_write(3, 3, {8'h80, $random(seed)}, 16'($random(seed)));
			run_ports();
		end

		while (exp_rcmd.size() != 0 || exp_wbeat.size() != 0)
			@(posedge fpu_clk);
		repeat (20) @(posedge fpu_clk);     // room for stray outputs
		if (!rcc_valid && !wcc_valid) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("outputs still active after all expected results");
			$display("Something failed");
			$fatal(1, "trailing output");
		end
	end

endmodule

`default_nettype wire

//--- list.f
source/dma_path_pkg.sv
source/sync_fifo.sv
source/port_arbiter.sv
source/cmd_dispatch.sv
source/write_issuer.sv
source/dma_path_top.sv
tests/dma_path_props.sv
tests/tb_dma_path.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_dma_path
FILELIST  := list.f
FLAGS     := -sv --timing --assert
BUILD     := obj_dir
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
